/* video_pkg.sv */
/*
 * video pattern package
 * raster geometry, colours and I2S framing constants
 * with the vector types shared by the pattern generator
 */
package video_pkg;

    ////////////////////
    // vector types
    ////////////////////

    // raster counter or visible coordinate
    typedef logic [9:0] coord_t;

    // one pixel, red in the top byte
    typedef logic [23:0] rgb_t;

    // bit clock count inside one I2S channel
    typedef logic [4:0] lrck_cnt_t;

    ////////////////////
    // raster geometry
    ////////////////////

    // line length, visible width and left border in pixel clocks
    localparam int h_total = 400;
    localparam int h_active = 320;
    localparam int h_bporch = 10;

    // frame height, visible height and top border in lines
    localparam int v_total = 512;
    localparam int v_active = 240;
    localparam int v_bporch = 10;

    // hs position on the line
    // kept off x = 0 so hs never lands on the vs cycle
    localparam int hs_x = 3;

    ////////////////////
    // picture content
    ////////////////////

    // square edge in pixels
    localparam int square_size = 10;

    // per channel background level
    localparam logic [7:0] grey_level = 8'd60;

    // bit clocks per I2S channel
    localparam int lrck_half_bits = 32;

endpackage

/* raster_if.sv */
/*
 * raster bus
 * carries the current raster position and its decoded
 * window flags from the timing block to its consumers
 */
`timescale 1ns/1ps

interface raster_if;

    // raw counters
    video_pkg::coord_t x;
    video_pkg::coord_t y;

    // high for the single clock at x = 0, y = 0
    logic frame_start;

    // inside the visible window
    logic in_active;

    // counters minus the borders
    // only meaningful while in_active is high
    video_pkg::coord_t vis_x;
    video_pkg::coord_t vis_y;

    modport source (output x, y, frame_start, in_active, vis_x, vis_y);
    modport sink (input x, y, frame_start, in_active, vis_x, vis_y);

endinterface

/* video_timing.sv */
/*
 * video timing
 * free running horizontal and vertical counters with
 * frame start, active window and visible coordinate decode
 */
`timescale 1ns/1ps

module video_timing (
    input logic audgen_mclk,
    input logic reset_n,
    raster_if.source raster
);

    video_pkg::coord_t x_cnt;
    video_pkg::coord_t y_cnt;
    logic x_wrap;
    logic y_wrap;
    logic h_act;
    logic v_act;

    ////////////////////
    // counters
    ////////////////////

    assign x_wrap = (x_cnt == video_pkg::coord_t'(video_pkg::h_total - 1));
    assign y_wrap = (y_cnt == video_pkg::coord_t'(video_pkg::v_total - 1));

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            // x steps every clock
            if (x_wrap) begin
                x_cnt <= '0;
                // y steps once per line
                if (y_wrap) begin
                    y_cnt <= '0;
                end else begin
                    y_cnt <= y_cnt + 1'b1;
                end
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // window decode
    ////////////////////

    assign h_act = (x_cnt >= video_pkg::coord_t'(video_pkg::h_bporch)) &&
        (x_cnt < video_pkg::coord_t'(video_pkg::h_bporch + video_pkg::h_active));
    assign v_act = (y_cnt >= video_pkg::coord_t'(video_pkg::v_bporch)) &&
        (y_cnt < video_pkg::coord_t'(video_pkg::v_bporch + video_pkg::v_active));

    assign raster.x = x_cnt;
    assign raster.y = y_cnt;
    assign raster.frame_start = (x_cnt == '0) && (y_cnt == '0);
    assign raster.in_active = h_act && v_act;

    // wraps outside the window, gated by in_active downstream
    assign raster.vis_x = video_pkg::coord_t'(x_cnt - video_pkg::coord_t'(video_pkg::h_bporch));
    assign raster.vis_y = video_pkg::coord_t'(y_cnt - video_pkg::coord_t'(video_pkg::v_bporch));

endmodule

/* square_mover.sv */
/*
 * square mover
 * steps the square one pixel per axis each frame and
 * reverses an axis when it reaches 0 or the window limit
 */
`timescale 1ns/1ps

module square_mover #(
    parameter video_pkg::coord_t start_x = 10'd135,
    parameter video_pkg::coord_t start_y = 10'd95
) (
    input logic audgen_mclk,
    input logic reset_n,
    raster_if.sink raster,
    output video_pkg::coord_t square_x,
    output video_pkg::coord_t square_y
);

    // direction bits, high while moving toward 0
    logic dec_x;
    logic dec_y;

    video_pkg::coord_t next_x;
    video_pkg::coord_t next_y;
    logic bounce_x;
    logic bounce_y;

    ////////////////////
    // next position
    ////////////////////

    assign next_x = dec_x ? square_x - 1'b1 : square_x + 1'b1;
    assign next_y = dec_y ? square_y - 1'b1 : square_y + 1'b1;

    // reverse once the new position touches an edge
    // far edge is the last top left position that keeps the square inside
    assign bounce_x = (next_x == '0) ||
        (next_x == video_pkg::coord_t'(video_pkg::h_active - video_pkg::square_size));
    assign bounce_y = (next_y == '0) ||
        (next_y == video_pkg::coord_t'(video_pkg::v_active - video_pkg::square_size));

    ////////////////////
    // frame update
    ////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            square_x <= start_x;
            square_y <= start_y;
            // both axes start at +1
            dec_x <= 1'b0;
            dec_y <= 1'b0;
        end else if (raster.frame_start) begin
            // update at (0,0) so each visible frame sees one position
            square_x <= next_x;
            square_y <= next_y;
            if (bounce_x) begin
                dec_x <= ~dec_x;
            end
            if (bounce_y) begin
                dec_y <= ~dec_y;
            end
        end
    end

endmodule

/* pixel_shader.sv */
/*
 * pixel shader
 * registered syncs, data enable and colour for each raster
 * position, grey field with a black square in the window
 */
`timescale 1ns/1ps

module pixel_shader (
    input logic audgen_mclk,
    input logic reset_n,
    raster_if.sink raster,
    input video_pkg::coord_t square_x,
    input video_pkg::coord_t square_y,
    output video_pkg::rgb_t video_rgb,
    output logic video_de,
    output logic video_vs,
    output logic video_hs
);

    video_pkg::coord_t square_x_end;
    video_pkg::coord_t square_y_end;
    logic in_square;

    ////////////////////
    // square hit test
    ////////////////////

    // exclusive right and bottom edges
    assign square_x_end = square_x + video_pkg::coord_t'(video_pkg::square_size);
    assign square_y_end = square_y + video_pkg::coord_t'(video_pkg::square_size);

    assign in_square = (raster.vis_x >= square_x) && (raster.vis_x < square_x_end) &&
        (raster.vis_y >= square_y) && (raster.vis_y < square_y_end);

    ////////////////////
    // output registers
    ////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= '0;
            video_de <= 1'b0;
            video_vs <= 1'b0;
            video_hs <= 1'b0;
        end else begin
            // one clock pulses
            video_vs <= raster.frame_start;
            video_hs <= (raster.x == video_pkg::coord_t'(video_pkg::hs_x));
            video_de <= raster.in_active;
            // borders are black
            if (!raster.in_active || in_square) begin
                video_rgb <= '0;
            end else begin
                video_rgb <= video_pkg::rgb_t'({3{video_pkg::grey_level}});
            end
        end
    end

endmodule

/* i2s_lrck_gen.sv */
/*
 * I2S frame clock
 * divides mclk by four for sclk and toggles lrck
 * every 32 bit clocks, all on the mclk domain
 */
`timescale 1ns/1ps

module i2s_lrck_gen (
    input logic audgen_mclk,
    input logic reset_n,
    output logic audio_sclk,
    output logic audio_lrck
);

    logic [1:0] mclk_div;
    video_pkg::lrck_cnt_t bit_cnt;
    logic sclk_fall;

    // sclk is the divider msb
    assign audio_sclk = mclk_div[1];

    // divider at 3 means sclk falls on this edge
    assign sclk_fall = (mclk_div == 2'd3);

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            mclk_div <= '0;
            bit_cnt <= '0;
            audio_lrck <= 1'b0;
        end else begin
            mclk_div <= mclk_div + 1'b1;
            if (sclk_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
                // swap channel after the last bit
                if (bit_cnt == video_pkg::lrck_cnt_t'(video_pkg::lrck_half_bits - 1)) begin
                    audio_lrck <= ~audio_lrck;
                end
            end
        end
    end

endmodule

/* pattern_top.sv */
/*
 * pattern top
 * test pattern video with a bouncing square and the
 * I2S frame clock, all running on the audio master clock
 */
`timescale 1ns/1ps

module pattern_top #(
    parameter video_pkg::coord_t start_x = 10'd135,
    parameter video_pkg::coord_t start_y = 10'd95
) (
    input logic audgen_mclk,
    input logic reset_n,
    output video_pkg::rgb_t video_rgb,
    output logic video_de,
    output logic video_vs,
    output logic video_hs,
    output logic audio_sclk,
    output logic audio_lrck
);

    ////////////////////
    // video path
    ////////////////////

    raster_if raster_bus ();

    video_pkg::coord_t square_x;
    video_pkg::coord_t square_y;

    video_timing timing_i (
        .audgen_mclk (audgen_mclk),
        .reset_n (reset_n),
        .raster (raster_bus.source)
    );

    // position steps at frame start
    square_mover #(
        .start_x (start_x),
        .start_y (start_y)
    ) mover_i (
        .audgen_mclk (audgen_mclk),
        .reset_n (reset_n),
        .raster (raster_bus.sink),
        .square_x (square_x),
        .square_y (square_y)
    );

    pixel_shader shader_i (
        .audgen_mclk (audgen_mclk),
        .reset_n (reset_n),
        .raster (raster_bus.sink),
        .square_x (square_x),
        .square_y (square_y),
        .video_rgb (video_rgb),
        .video_de (video_de),
        .video_vs (video_vs),
        .video_hs (video_hs)
    );

    ////////////////////
    // audio framing
    ////////////////////

    i2s_lrck_gen i2s_i (
        .audgen_mclk (audgen_mclk),
        .reset_n (reset_n),
        .audio_sclk (audio_sclk),
        .audio_lrck (audio_lrck)
    );

endmodule

/* pattern_top_chk.sv */
/*
 * pattern top assertions
 * one clock syncs, enable spacing after hs and
 * lrck changes aligned to the sclk falling edge
 */
`timescale 1ns/1ps

module pattern_top_chk (
    input logic audgen_mclk,
    input logic reset_n,
    input logic video_vs,
    input logic video_hs,
    input logic video_de,
    input logic audio_sclk,
    input logic audio_lrck
);

    // number of failed assertions so far
    int assert_fails = 0;

    vs_one_clock: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video_vs |=> !video_vs)
        else begin
            $error("video_vs high for more than one clock");
            assert_fails++;
        end

    hs_one_clock: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video_hs |=> !video_hs)
        else begin
            $error("video_hs high for more than one clock");
            assert_fails++;
        end

    // de rises 7 clocks after hs, never inside the first 3
    de_after_hs: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $rose(video_de) |-> !video_hs && !$past(video_hs) &&
            !$past(video_hs, 2) && !$past(video_hs, 3))
        else begin
            $error("video_de rose within 3 clocks of video_hs");
            assert_fails++;
        end

    lrck_on_sclk_fall: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> $fell(audio_sclk))
        else begin
            $error("audio_lrck changed away from an audio_sclk falling edge");
            assert_fails++;
        end

endmodule

bind pattern_top pattern_top_chk chk_i (.*);

/* tb_pattern_top.sv */
/*
 * pattern top testbench
 * directed tests for sync, window, colours, bounce, I2S framing
 * and mid run reset against a model of the raster and motion
 */
`timescale 1ns/1ps

module tb_pattern_top;

    localparam int clk_period = 10;
    // start close to the far edges so both axes bounce early
    localparam video_pkg::coord_t start_x = 10'd306;
    localparam video_pkg::coord_t start_y = 10'd226;
    localparam int frame_clks = video_pkg::h_total * video_pkg::v_total;
    localparam int x_lim = video_pkg::h_active - video_pkg::square_size;
    localparam int y_lim = video_pkg::v_active - video_pkg::square_size;
    // eight frames of tests, one more for i2s, reset wait and slack
    localparam int watchdog_clks = 9 * frame_clks;

    logic audgen_mclk = 1'b0;
    logic reset_n = 1'b0;
    video_pkg::rgb_t video_rgb;
    logic video_de;
    logic video_vs;
    logic video_hs;
    logic audio_sclk;
    logic audio_lrck;

    // samples since reset release, sample k shows raster position k-1
    int k = 0;
    logic [31:0] lfsr = 32'h9f94_935b;

    pattern_top #(.start_x(start_x), .start_y(start_y)) dut_i (.*);

    always #(clk_period / 2) audgen_mclk = ~audgen_mclk;

    ////////////////////
    // helpers
    ////////////////////

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // galois lfsr, one step per bit taken
    function automatic int unsigned rand_bits(int n);
        int unsigned r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            r = (r << 1) | lfsr[0];
        end
        return r;
    endfunction

    task automatic compare_rgb(video_pkg::rgb_t act, video_pkg::rgb_t exp, string name);
        if (act !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s got %h, expected %h",
                $time, name, act, exp));
        end
    endtask

    task automatic compare_bit(logic act, logic exp, string name);
        if (act !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s got %b, expected %b",
                $time, name, act, exp));
        end
    endtask

    task automatic compare_coord(video_pkg::coord_t act, video_pkg::coord_t exp, string name);
        if (act !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s got %0d, expected %0d",
                $time, name, act, exp));
        end
    endtask

    task automatic step();
        @(negedge audgen_mclk);
        k++;
    endtask

    ////////////////////
    // reference model
    ////////////////////

    function automatic int raster_x(int p);
        return p % video_pkg::h_total;
    endfunction

    function automatic int raster_y(int p);
        return (p / video_pkg::h_total) % video_pkg::v_total;
    endfunction

    function automatic logic exp_active(int p);
        return raster_x(p) >= video_pkg::h_bporch &&
            raster_x(p) < video_pkg::h_bporch + video_pkg::h_active &&
            raster_y(p) >= video_pkg::v_bporch &&
            raster_y(p) < video_pkg::v_bporch + video_pkg::v_active;
    endfunction

    // square position drawn in frame n, one step already taken at frame 0
    function automatic video_pkg::coord_t model_pos(int start, int limit, int n);
        int pos;
        int vel;
        pos = start;
        vel = 1;
        for (int i = 0; i <= n; i++) begin
            pos = pos + vel;
            if (pos == 0 || pos == limit) begin
                vel = -vel;
            end
        end
        return video_pkg::coord_t'(pos);
    endfunction

    function automatic video_pkg::rgb_t exp_rgb(int p);
        int vx;
        int vy;
        int sx;
        int sy;
        vx = raster_x(p) - video_pkg::h_bporch;
        vy = raster_y(p) - video_pkg::v_bporch;
        sx = model_pos(start_x, x_lim, p / frame_clks);
        sy = model_pos(start_y, y_lim, p / frame_clks);
        if (!exp_active(p)) begin
            return '0;
        end
        if (vx >= sx && vx < sx + video_pkg::square_size &&
            vy >= sy && vy < sy + video_pkg::square_size) begin
            return '0;
        end
        return 24'h3c3c3c;
    endfunction

    task automatic check_sync();
        compare_bit(video_vs, (k - 1) % frame_clks == 0, "video_vs");
        compare_bit(video_hs, raster_x(k - 1) == video_pkg::hs_x, "video_hs");
    endtask

    // two cycles of reset, outputs checked low while it is held
    task automatic apply_reset();
        reset_n = 1'b0;
        @(negedge audgen_mclk);
        compare_rgb(video_rgb, '0, "video_rgb");
        compare_bit(video_de, 1'b0, "video_de");
        compare_bit(video_vs, 1'b0, "video_vs");
        compare_bit(video_hs, 1'b0, "video_hs");
        compare_bit(audio_sclk, 1'b0, "audio_sclk");
        compare_bit(audio_lrck, 1'b0, "audio_lrck");
        @(negedge audgen_mclk);
        reset_n = 1'b1;
        k = 0;
    endtask

    ////////////////////
    // tests
    ////////////////////

    // frame 0 through the second vs
    task automatic test_sync();
        while (k <= frame_clks) begin
            step();
            check_sync();
        end
    endtask

    // frame 1, enable per clock and black borders
    task automatic test_window();
        video_pkg::coord_t lines = '0;
        logic prev_de = 1'b0;
        while (k < 2 * frame_clks) begin
            step();
            compare_bit(video_de, exp_active(k - 1), "video_de");
            if (!video_de) begin
                compare_rgb(video_rgb, '0, "video_rgb");
            end
            if (video_de && !prev_de) begin
                lines++;
            end
            prev_de = video_de;
        end
        compare_coord(lines, video_pkg::coord_t'(video_pkg::v_active), "de_lines");
    endtask

    // sclk period 4, lrck half period 128
    task automatic test_i2s();
        repeat (520) begin
            step();
            compare_bit(audio_sclk, (k % 4) >= 2, "audio_sclk");
            compare_bit(audio_lrck, (k / 128) % 2 == 1, "audio_lrck");
        end
    endtask

    task automatic test_reset_mid();
        int wait_clks;
        wait_clks = rand_bits(12) + 1;
        repeat (wait_clks) begin
            step();
        end
        apply_reset();
        repeat (8) begin
            step();
            check_sync();
        end
    endtask

    // top left black pixel of frames 0 to 4
    task automatic test_bounce();
        video_pkg::coord_t fx;
        video_pkg::coord_t fy;
        logic found;
        for (int n = 0; n < 5; n++) begin
            found = 1'b0;
            while (k < (n + 1) * frame_clks) begin
                step();
                if (!found && video_de && video_rgb == '0) begin
                    found = 1'b1;
                    fx = video_pkg::coord_t'(raster_x(k - 1) - video_pkg::h_bporch);
                    fy = video_pkg::coord_t'(raster_y(k - 1) - video_pkg::v_bporch);
                end
            end
            if (!found) begin
                abort_run($sformatf("no black square pixel seen in frame %0d", n));
            end
            compare_coord(fx, model_pos(start_x, x_lim, n), "square_x");
            compare_coord(fy, model_pos(start_y, y_lim, n), "square_y");
        end
    endtask

    // one random column per visible line, near the square on its rows
    task automatic test_colours();
        int n;
        int sx;
        int sy;
        int col;
        int p;
        n = k / frame_clks;
        sx = model_pos(start_x, x_lim, n);
        sy = model_pos(start_y, y_lim, n);
        for (int y = 0; y < video_pkg::v_active; y++) begin
            if (y + 5 >= sy && y < sy + 15) begin
                col = sx - 5 + int'(rand_bits(5) % 20);
            end else begin
                col = int'(rand_bits(9) % 320);
            end
            col = (col < 0) ? 0 : ((col >= video_pkg::h_active) ? video_pkg::h_active - 1 : col);
            p = n * frame_clks + (y + video_pkg::v_bporch) * video_pkg::h_total +
                col + video_pkg::h_bporch;
            while (k - 1 < p) begin
                step();
            end
            compare_rgb(video_rgb, exp_rgb(p), "video_rgb");
        end
    endtask

    ////////////////////
    // run control
    ////////////////////

    always @(negedge audgen_mclk) begin
        if (dut_i.chk_i.assert_fails != 0) begin
            abort_run("an assertion on the DUT outputs failed");
        end
    end

    initial begin
        #(watchdog_clks * clk_period);
        abort_run("timeout, the tests did not complete in time");
    end

    initial begin
        apply_reset();
        test_sync();
        test_window();
        test_i2s();
        test_reset_mid();
        test_bounce();
        test_colours();
        @(negedge audgen_mclk);
        if (dut_i.chk_i.assert_fails == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

endmodule

/* tb.f */
video_pkg.sv
raster_if.sv
video_timing.sv
square_mover.sv
pixel_shader.sv
i2s_lrck_gen.sv
pattern_top.sv
pattern_top_chk.sv
tb_pattern_top.sv
